//--- logic/iq_macros.svh
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// queue geometry
`define IQ_DEPTH 8
`define IQ_IDX_W 3

// field widths
`define PREG_W 6
`define ROB_IDX_W 5
`define IMM_W 32
`define ALU_TYPE_W 4

`endif

//--- logic/iq_pkg.sv
`default_nettype none

`include "iq_macros.svh"

package iq_pkg;

    typedef logic [`PREG_W-1:0] preg_t;

    // wrap flag sits above the index so age compares stay simple
    typedef struct packed {
        logic                  flag;
        logic [`ROB_IDX_W-1:0] idx;
    } rob_tag_t;

    typedef struct packed {
        preg_t tag;
        logic  is_reg;
        logic  pending;
    } src_t;

    typedef struct packed {
        preg_t                  prd;
        preg_t                  old_prd;
        logic [`IMM_W-1:0]      imm;
        logic [`ALU_TYPE_W-1:0] alu_type;
        logic                   is_load;
        logic                   is_store;
        logic [3:0]             ls_size;
        logic                   need_to_wb;
    } uop_t;

    typedef struct packed {
        uop_t     uop;
        src_t     src1;
        src_t     src2;
        rob_tag_t rob;
    } enq_req_t;

    typedef struct packed {
        logic  valid;
        logic  need_to_wb;
        preg_t prd;
    } wb_t;

    // what the execution unit sees
    typedef struct packed {
        uop_t     uop;
        preg_t    prs1;
        logic     src1_is_reg;
        preg_t    prs2;
        logic     src2_is_reg;
        rob_tag_t rob;
    } issue_t;

endpackage

`default_nettype wire

//--- logic/payload_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module payload_store (
    input  logic                 clock,
    input  logic                 enq_fire,
    input  logic [`IQ_IDX_W-1:0] enq_slot,
    input  iq_pkg::uop_t         enq_uop,
    input  logic [`IQ_IDX_W-1:0] sel_idx,
    output iq_pkg::uop_t         sel_uop
);

    import iq_pkg::*;

    // one payload per entry, valid bits live in issue_control
    uop_t entries [`IQ_DEPTH];

    always_ff @(posedge clock) begin
        if (enq_fire) begin
            entries[enq_slot] <= enq_uop;
        end
    end

    // read port for the selected entry, no latency
    assign sel_uop = entries[sel_idx];

endmodule

`default_nettype wire

//--- logic/operand_wakeup.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module operand_wakeup (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 enq_fire,
    input  logic [`IQ_IDX_W-1:0] enq_slot,
    input  iq_pkg::src_t         enq_src1,
    input  iq_pkg::src_t         enq_src2,
    input  iq_pkg::wb_t          wb0,
    input  iq_pkg::wb_t          wb1,
    input  logic [`IQ_IDX_W-1:0] sel_idx,
    output iq_pkg::src_t         sel_src1,
    output iq_pkg::src_t         sel_src2,
    output logic [`IQ_DEPTH-1:0] operands_ready
);

    import iq_pkg::*;

    // index 0 is source 1, index 1 is source 2
    preg_t                       tag [2][`IQ_DEPTH];
    logic [1:0][`IQ_DEPTH-1:0]   is_reg;
    logic [1:0][`IQ_DEPTH-1:0]   pending;
    src_t                        enq_src [2];
    logic [`IQ_DEPTH-1:0]        enq_oh;

    // a writeback wakes a tag only if it really writes the register file
    function automatic logic wb_hit(input preg_t t);
        return (wb0.valid && wb0.need_to_wb && (wb0.prd == t)) ||
               (wb1.valid && wb1.need_to_wb && (wb1.prd == t));
    endfunction

    assign enq_src[0] = enq_src1;
    assign enq_src[1] = enq_src2;
    assign enq_oh     = {{(`IQ_DEPTH-1){1'b0}}, enq_fire} << enq_slot;

    // tags and is_reg are payload
    always_ff @(posedge clock) begin
        if (enq_fire) begin
            for (int s = 0; s < 2; s++) begin
                tag[s][enq_slot]    <= enq_src[s].tag;
                is_reg[s][enq_slot] <= enq_src[s].is_reg;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pending <= '0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                for (int i = 0; i < `IQ_DEPTH; i++) begin
                    if (enq_oh[i]) begin
                        // bypass when the producer writes back this very cycle
                        pending[s][i] <= enq_src[s].is_reg && enq_src[s].pending &&
                                         !wb_hit(enq_src[s].tag);
                    end else if (wb_hit(tag[s][i])) begin
                        pending[s][i] <= 1'b0;
                    end
                end
            end
        end
    end

    // only register sources are ever set pending
    assign operands_ready = ~(pending[0] | pending[1]);

    assign sel_src1 = '{tag: tag[0][sel_idx], is_reg: is_reg[0][sel_idx],
                        pending: pending[0][sel_idx]};
    assign sel_src2 = '{tag: tag[1][sel_idx], is_reg: is_reg[1][sel_idx],
                        pending: pending[1][sel_idx]};

endmodule

`default_nettype wire

//--- logic/issue_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module issue_control (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 enq_valid,
    input  iq_pkg::rob_tag_t     enq_rob,
    output logic                 enq_ready,
    output logic                 enq_fire,
    output logic [`IQ_IDX_W-1:0] enq_slot,
    input  logic [`IQ_DEPTH-1:0] operands_ready,
    input  logic                 flush_valid,
    input  iq_pkg::rob_tag_t     flush_rob,
    input  logic                 deq_ready,
    output logic [`IQ_IDX_W-1:0] sel_idx,
    input  iq_pkg::uop_t         sel_uop,
    input  iq_pkg::src_t         sel_src1,
    input  iq_pkg::src_t         sel_src2,
    output logic                 deq_valid,
    output iq_pkg::issue_t       deq_data
);

    import iq_pkg::*;

    logic [`IQ_DEPTH-1:0] valid;
    rob_tag_t             rob [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] flush_hit;
    logic [`IQ_DEPTH-1:0] issuable;
    logic [`IQ_DEPTH-1:0] enq_oh;
    logic [`IQ_DEPTH-1:0] sel_oh;
    logic                 sel_fire;

    // priority encoder, lowest index wins
    function automatic logic [`IQ_IDX_W-1:0] lowest_set(input logic [`IQ_DEPTH-1:0] vec);
        logic [`IQ_IDX_W-1:0] idx;
        idx = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = i[`IQ_IDX_W-1:0];
            end
        end
        return idx;
    endfunction

    // enqueue side
    assign enq_ready = ~&valid;
    assign enq_fire  = enq_valid && enq_ready;
    assign enq_slot  = lowest_set(~valid);
    assign enq_oh    = {{(`IQ_DEPTH-1){1'b0}}, enq_fire} << enq_slot;

    // younger than the redirect point: flags differ flips the index compare
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            flush_hit[i] = flush_valid && valid[i] &&
                           (rob[i].flag ^ flush_rob.flag ^ (flush_rob.idx < rob[i].idx));
        end
    end

    // select side, a flushed entry must not slip out
    assign issuable = valid & operands_ready & ~flush_hit;
    assign sel_fire = deq_ready && (|issuable);
    assign sel_idx  = lowest_set(issuable);
    assign sel_oh   = {{(`IQ_DEPTH-1){1'b0}}, sel_fire} << sel_idx;

    // enq_oh only ever points at a free slot
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~flush_hit & ~sel_oh) | enq_oh;
        end
    end

    always_ff @(posedge clock) begin
        if (enq_fire) begin
            rob[enq_slot] <= enq_rob;
        end
    end

    // issue output register
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            deq_valid <= 1'b0;
        end else begin
            deq_valid <= sel_fire;
        end
    end

    always_ff @(posedge clock) begin
        if (sel_fire) begin
            deq_data.uop         <= sel_uop;
            deq_data.prs1        <= sel_src1.tag;
            deq_data.src1_is_reg <= sel_src1.is_reg;
            deq_data.prs2        <= sel_src2.tag;
            deq_data.src2_is_reg <= sel_src2.is_reg;
            deq_data.rob         <= rob[sel_idx];
        end
    end

endmodule

`default_nettype wire

//--- logic/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module issue_queue (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               enq_valid,
    input  iq_pkg::enq_req_t   enq_req,
    output logic               enq_ready,
    input  iq_pkg::wb_t        wb0,
    input  iq_pkg::wb_t        wb1,
    input  logic               flush_valid,
    input  iq_pkg::rob_tag_t   flush_rob,
    input  logic               deq_ready,
    output logic               deq_valid,
    output iq_pkg::issue_t     deq_data
);

    import iq_pkg::*;

    logic                 enq_fire;
    logic [`IQ_IDX_W-1:0] enq_slot;
    logic [`IQ_IDX_W-1:0] sel_idx;
    uop_t                 sel_uop;
    src_t                 sel_src1;
    src_t                 sel_src2;
    logic [`IQ_DEPTH-1:0] operands_ready;

    payload_store u_payload (
        .clock    (clock),
        .enq_fire (enq_fire),
        .enq_slot (enq_slot),
        .enq_uop  (enq_req.uop),
        .sel_idx  (sel_idx),
        .sel_uop  (sel_uop)
    );

    operand_wakeup u_wakeup (
        .clock          (clock),
        .reset_n        (reset_n),
        .enq_fire       (enq_fire),
        .enq_slot       (enq_slot),
        .enq_src1       (enq_req.src1),
        .enq_src2       (enq_req.src2),
        .wb0            (wb0),
        .wb1            (wb1),
        .sel_idx        (sel_idx),
        .sel_src1       (sel_src1),
        .sel_src2       (sel_src2),
        .operands_ready (operands_ready)
    );

    issue_control u_control (
        .clock          (clock),
        .reset_n        (reset_n),
        .enq_valid      (enq_valid),
        .enq_rob        (enq_req.rob),
        .enq_ready      (enq_ready),
        .enq_fire       (enq_fire),
        .enq_slot       (enq_slot),
        .operands_ready (operands_ready),
        .flush_valid    (flush_valid),
        .flush_rob      (flush_rob),
        .deq_ready      (deq_ready),
        .sel_idx        (sel_idx),
        .sel_uop        (sel_uop),
        .sel_src1       (sel_src1),
        .sel_src2       (sel_src2),
        .deq_valid      (deq_valid),
        .deq_data       (deq_data)
    );

endmodule

`default_nettype wire

//--- test/issue_queue_chk.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue_chk (
    input logic clock,
    input logic reset_n,
    input logic enq_fire,
    input logic enq_ready,
    input logic deq_valid,
    input logic deq_ready
);

    int unsigned errors = 0;

    // issue register is cleared by the asynchronous reset
    deq_low_in_reset: assert property (@(posedge clock) !reset_n |=> !deq_valid)
        else begin
            $error("deq_valid high while reset is applied");
            errors++;
        end

    enq_only_when_ready: assert property (
        @(posedge clock) disable iff (!reset_n) enq_fire |-> enq_ready)
        else begin
            $error("enqueue fired while enq_ready was low");
            errors++;
        end

    // a stalled execution unit sees at most one pending issue
    no_issue_under_stall: assert property (
        @(posedge clock) disable iff (!reset_n) (deq_valid && !deq_ready) |=> !deq_valid)
        else begin
            $error("deq_valid stayed high while deq_ready was low");
            errors++;
        end

endmodule

bind issue_queue issue_queue_chk u_chk (
    .clock     (clock),
    .reset_n   (reset_n),
    .enq_fire  (enq_fire),
    .enq_ready (enq_ready),
    .deq_valid (deq_valid),
    .deq_ready (deq_ready)
);

`default_nettype wire

//--- test/issue_queue_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue_monitor (
    input logic           clock,
    input logic           reset_n,
    input logic           enq_ready,
    input logic           deq_valid,
    input iq_pkg::issue_t deq_data
);

    import iq_pkg::*;

    issue_t expected [$];
    issue_t want;
    int     errors = 0;

    task automatic push_expected(input issue_t rec);
        expected.push_back(rec);
    endtask

    function automatic int outstanding();
        return expected.size();
    endfunction

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_enq_ready(input logic exp);
        compare_field("enq_ready", enq_ready, exp);
    endtask

    task automatic report_missing();
        if (expected.size() != 0) begin
            $display("%0d expected issues never appeared", expected.size());
            errors += expected.size();
        end
    endtask

    // issue register changes on the rising edge, so look in the middle
    always @(negedge clock) begin
        if (reset_n && deq_valid) begin
            if (expected.size() == 0) begin
                $display("an issue arrived with none expected, rob tag 0x%0h", deq_data.rob);
                errors++;
            end else begin
                want = expected.pop_front();
                compare_field("deq_data.uop.prd", deq_data.uop.prd, want.uop.prd);
                compare_field("deq_data.uop.old_prd", deq_data.uop.old_prd, want.uop.old_prd);
                compare_field("deq_data.uop.imm", deq_data.uop.imm, want.uop.imm);
                compare_field("deq_data.uop.alu_type", deq_data.uop.alu_type,
                              want.uop.alu_type);
                compare_field("deq_data.uop.is_load", deq_data.uop.is_load, want.uop.is_load);
                compare_field("deq_data.uop.is_store", deq_data.uop.is_store,
                              want.uop.is_store);
                compare_field("deq_data.uop.ls_size", deq_data.uop.ls_size, want.uop.ls_size);
                compare_field("deq_data.uop.need_to_wb", deq_data.uop.need_to_wb,
                              want.uop.need_to_wb);
                compare_field("deq_data.prs1", deq_data.prs1, want.prs1);
                compare_field("deq_data.src1_is_reg", deq_data.src1_is_reg, want.src1_is_reg);
                compare_field("deq_data.prs2", deq_data.prs2, want.prs2);
                compare_field("deq_data.src2_is_reg", deq_data.src2_is_reg, want.src2_is_reg);
                compare_field("deq_data.rob", deq_data.rob, want.rob);
            end
        end
    end

endmodule

`default_nettype wire

//--- test/issue_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue_tb;

    import iq_pkg::*;

    localparam int unsigned rand_seed   = 32'h8e12cf1b;
    localparam time         half_period = 50ns;
    localparam int          ready_limit = 20;
    localparam int          issue_limit = 20;

    typedef enum {step_enq, step_wb, step_flush, step_hold} step_kind_t;

    typedef struct {
        step_kind_t kind;
        int         op;
        wb_t        wb;
        rob_tag_t   rob;
        int         cycles;
        // ops exp_first .. exp_first + exp_count - 1 issue in this order
        int         exp_first;
        int         exp_count;
        int         ready_chk;
    } step_t;

    logic     clock;
    logic     reset_n;
    logic     enq_valid;
    enq_req_t enq_req;
    logic     enq_ready;
    wb_t      wb0;
    wb_t      wb1;
    logic     flush_valid;
    rob_tag_t flush_rob;
    logic     deq_ready;
    logic     deq_valid;
    issue_t   deq_data;

    enq_req_t ops [$];
    step_t    steps [$];
    int       timeouts;

    issue_queue u_dut (
        .clock       (clock),
        .reset_n     (reset_n),
        .enq_valid   (enq_valid),
        .enq_req     (enq_req),
        .enq_ready   (enq_ready),
        .wb0         (wb0),
        .wb1         (wb1),
        .flush_valid (flush_valid),
        .flush_rob   (flush_rob),
        .deq_ready   (deq_ready),
        .deq_valid   (deq_valid),
        .deq_data    (deq_data)
    );

    issue_queue_monitor u_mon (
        .clock     (clock),
        .reset_n   (reset_n),
        .enq_ready (enq_ready),
        .deq_valid (deq_valid),
        .deq_data  (deq_data)
    );

    always #half_period clock = ~clock;

    // tag 0 marks a source that is not a register
    function automatic void add_enqueue(input logic [5:0] rob, input preg_t t1, input logic p1,
                                        input preg_t t2, input logic p2, input preg_t bypass,
                                        input int exp_count, input int ready_chk);
        enq_req_t req;
        step_t    st;
        int       id;
        id = ops.size();
        req.uop = '{prd: preg_t'(id + 32), old_prd: preg_t'(id), imm: $urandom(),
                    alu_type: 4'($urandom()), is_load: id[0], is_store: id[1],
                    ls_size: 4'(id), need_to_wb: 1'b1};
        req.src1 = '{tag: t1, is_reg: t1 != 0, pending: p1};
        req.src2 = '{tag: t2, is_reg: t2 != 0, pending: p2};
        req.rob = rob_tag_t'(rob);
        ops.push_back(req);
        st = '{kind: step_enq, op: id, wb: '{valid: bypass != 0, need_to_wb: 1'b1, prd: bypass},
               rob: '0, cycles: 0, exp_first: id, exp_count: exp_count, ready_chk: ready_chk};
        steps.push_back(st);
    endfunction

    function automatic void add_event(input step_kind_t kind, input preg_t tag, input logic need,
                                      input logic [5:0] rob, input int cycles,
                                      input int exp_first, input int exp_count,
                                      input int ready_chk);
        step_t st;
        st = '{kind: kind, op: 0, wb: '{valid: tag != 0, need_to_wb: need, prd: tag},
               rob: rob_tag_t'(rob), cycles: cycles, exp_first: exp_first,
               exp_count: exp_count, ready_chk: ready_chk};
        steps.push_back(st);
    endfunction

    function automatic void build_table();
        // ready sources issue straight away
        add_enqueue(6'h00, 6'd5, 1'b0, 6'd0, 1'b1, 6'd0, 1, -1);
        add_enqueue(6'h01, 6'd6, 1'b0, 6'd7, 1'b0, 6'd0, 1, -1);
        add_enqueue(6'h02, 6'd0, 1'b1, 6'd0, 1'b0, 6'd0, 1, -1);
        // wakeup, the ignored writeback and the enqueue bypass
        add_enqueue(6'h03, 6'd10, 1'b1, 6'd0, 1'b0, 6'd0, 0, -1);
        add_event(step_wb, 6'd10, 1'b0, 6'h00, 0, 0, 0, -1);
        add_event(step_wb, 6'd10, 1'b1, 6'h00, 0, 3, 1, -1);
        add_enqueue(6'h04, 6'd11, 1'b1, 6'd0, 1'b0, 6'd11, 1, -1);
        // fill all eight slots
        // rob tags wrap after op 8
        add_enqueue(6'h1c, 6'd20, 1'b1, 6'd0, 1'b0, 6'd0, 0, 1);
        add_enqueue(6'h1d, 6'd21, 1'b1, 6'd0, 1'b0, 6'd0, 0, 1);
        add_enqueue(6'h1e, 6'd22, 1'b1, 6'd0, 1'b0, 6'd0, 0, 1);
        add_enqueue(6'h1f, 6'd23, 1'b1, 6'd0, 1'b0, 6'd0, 0, 1);
        add_enqueue(6'h20, 6'd24, 1'b1, 6'd0, 1'b0, 6'd0, 0, 1);
        add_enqueue(6'h21, 6'd25, 1'b1, 6'd0, 1'b0, 6'd0, 0, 1);
        add_enqueue(6'h22, 6'd26, 1'b1, 6'd0, 1'b0, 6'd0, 0, 1);
        add_enqueue(6'h23, 6'd27, 1'b1, 6'd0, 1'b0, 6'd0, 0, 0);
        add_event(step_wb, 6'd20, 1'b1, 6'h00, 0, 5, 1, 1);
        // redirect at rob 0x1e removes ops 8 to 12
        add_event(step_flush, 6'd0, 1'b0, 6'h1e, 0, 0, 0, -1);
        // none of the flushed ops may issue once woken
        add_event(step_wb, 6'd23, 1'b1, 6'h00, 0, 0, 0, -1);
        add_event(step_wb, 6'd24, 1'b1, 6'h00, 0, 0, 0, -1);
        add_event(step_wb, 6'd25, 1'b1, 6'h00, 0, 0, 0, -1);
        add_event(step_wb, 6'd26, 1'b1, 6'h00, 0, 0, 0, -1);
        add_event(step_wb, 6'd27, 1'b1, 6'h00, 0, 0, 0, -1);
        add_event(step_wb, 6'd21, 1'b1, 6'h00, 0, 6, 1, -1);
        add_event(step_wb, 6'd22, 1'b1, 6'h00, 0, 7, 1, 1);
        // four ops wake under a stall and drain in slot order
        add_enqueue(6'h24, 6'd30, 1'b1, 6'd31, 1'b0, 6'd0, 0, -1);
        add_enqueue(6'h25, 6'd30, 1'b1, 6'd31, 1'b0, 6'd0, 0, -1);
        add_enqueue(6'h26, 6'd30, 1'b1, 6'd31, 1'b0, 6'd0, 0, -1);
        add_enqueue(6'h27, 6'd30, 1'b1, 6'd31, 1'b0, 6'd0, 0, -1);
        add_event(step_hold, 6'd30, 1'b1, 6'h00, 4, 13, 4, -1);
    endfunction

    function automatic issue_t expected_issue(input enq_req_t r);
        return '{uop: r.uop, prs1: r.src1.tag, src1_is_reg: r.src1.is_reg,
                 prs2: r.src2.tag, src2_is_reg: r.src2.is_reg, rob: r.rob};
    endfunction

    task automatic wait_enq_ready(input int idx);
        int n;
        n = 0;
        while (!enq_ready && n < ready_limit) begin
            @(negedge clock);
            n++;
        end
        if (!enq_ready) begin
            $display("timeout waiting for enq_ready in step %0d", idx);
            timeouts++;
        end
    endtask

    task automatic wait_drained(input int idx);
        int n;
        n = 0;
        while (u_mon.outstanding() != 0 && n < issue_limit) begin
            @(negedge clock);
            n++;
        end
        if (u_mon.outstanding() != 0) begin
            $display("timeout waiting for expected issues in step %0d", idx);
            timeouts++;
        end
    endtask

    task automatic apply_step(input step_t st, input int idx);
        case (st.kind)
            step_enq: begin
                wait_enq_ready(idx);
                enq_valid = 1'b1;
                enq_req   = ops[st.op];
                wb1       = st.wb;
                @(negedge clock);
                enq_valid = 1'b0;
                wb1       = '0;
            end
            step_wb: begin
                wb0 = st.wb;
                @(negedge clock);
                wb0 = '0;
            end
            step_flush: begin
                flush_valid = 1'b1;
                flush_rob   = st.rob;
                @(negedge clock);
                flush_valid = 1'b0;
            end
            default: begin
                deq_ready = 1'b0;
                wb0       = st.wb;
                @(negedge clock);
                wb0 = '0;
                repeat (st.cycles - 1) @(negedge clock);
                deq_ready = 1'b1;
            end
        endcase
        for (int k = 0; k < st.exp_count; k++) begin
            u_mon.push_expected(expected_issue(ops[st.exp_first + k]));
        end
        // a quiet step still gets a few cycles to show a stray issue
        if (st.exp_count == 0) begin
            repeat (3) @(negedge clock);
        end else begin
            wait_drained(idx);
        end
        if (st.ready_chk >= 0) begin
            u_mon.check_enq_ready(st.ready_chk == 1);
        end
    endtask

    initial begin
        void'($urandom(rand_seed));
        clock       = 1'b0;
        reset_n     = 1'b0;
        enq_valid   = 1'b0;
        enq_req     = '0;
        wb0         = '0;
        wb1         = '0;
        flush_valid = 1'b0;
        flush_rob   = '0;
        deq_ready   = 1'b1;
        timeouts    = 0;
        build_table();
        repeat (5) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        foreach (steps[i]) begin
            apply_step(steps[i], i);
        end
        repeat (4) @(negedge clock);
        u_mon.report_missing();
        $display("errors: %0d compare, %0d assertion, %0d timeout",
                 u_mon.errors, u_dut.u_chk.errors, timeouts);
        if (u_mon.errors == 0 && u_dut.u_chk.errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- issue_queue.f
+incdir+logic
logic/iq_pkg.sv
logic/payload_store.sv
logic/operand_wakeup.sv
logic/issue_control.sv
logic/issue_queue.sv
test/issue_queue_chk.sv
test/issue_queue_monitor.sv
test/issue_queue_tb.sv

//--- Bender.yml
package:
  name: issue_queue

sources:
  - include_dirs:
      - logic
    files:
      - logic/iq_pkg.sv
      - logic/payload_store.sv
      - logic/operand_wakeup.sv
      - logic/issue_control.sv
      - logic/issue_queue.sv
  - target: test
    files:
      - test/issue_queue_chk.sv
      - test/issue_queue_monitor.sv
      - test/issue_queue_tb.sv
